//--- logic/hwpe_pkg.sv
// Accelerator subsystem shared types
// Widths, register map, engine kinds and bus structs

`default_nettype none

package hwpe_pkg;

  // Word widths
  typedef logic [31:0] data_t;
  typedef logic [31:0] addr_t;
  typedef logic [7:0]  cfg_id_t;
  typedef logic [15:0] len_t;
  typedef logic [7:0]  reg_off_t;

  localparam int unsigned N_HWPES       = 2;
  localparam int unsigned HWPE_SEL_BITS = 1;
  localparam int unsigned N_CORES       = 8;
  localparam int unsigned FIFO_DEPTH    = 4;

  // Register map, byte offsets
  localparam reg_off_t REG_TRIGGER = 8'h00;
  localparam reg_off_t REG_STATUS  = 8'h04;
  localparam reg_off_t REG_BASE    = 8'h08;
  localparam reg_off_t REG_LEN     = 8'h0C;
  localparam reg_off_t REG_DEST    = 8'h10;
  localparam reg_off_t REG_RESULT  = 8'h14;
  localparam reg_off_t REG_KIND    = 8'h18;

  // Event bit pulsed at job end
  localparam int unsigned RESET_EVT_BIT = 0;

  typedef enum logic {
    KIND_SUM = 1'b0,
    KIND_MAX = 1'b1
  } hwpe_kind_e;

  localparam hwpe_kind_e ENGINE_KINDS [N_HWPES] = '{KIND_SUM, KIND_MAX};

  typedef enum logic {
    SRC_IDLE,
    SRC_FETCH
  } src_state_e;

  typedef enum logic [1:0] {
    SINK_IDLE,
    SINK_REDUCE,
    SINK_WRITE,
    SINK_DONE
  } sink_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // Bus structs, wen high means read
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic    req;
    addr_t   add;
    logic    wen;
    data_t   wdata;
    cfg_id_t id;
  } cfg_req_t;

  typedef struct packed {
    logic    gnt;
    logic    r_valid;
    data_t   r_data;
    cfg_id_t r_id;
  } cfg_rsp_t;

  typedef struct packed {
    logic  req;
    addr_t add;
    logic  wen;
    data_t data;
  } mem_req_t;

  typedef struct packed {
    logic  gnt;
    logic  r_valid;
    data_t r_data;
  } mem_rsp_t;

  typedef logic [N_CORES-1:0][1:0] evt_t;

endpackage

`default_nettype wire

//--- logic/hwpe_cfg_regs.sv
// Engine configuration registers

`timescale 1ns/100ps
`default_nettype none

module hwpe_cfg_regs
  import hwpe_pkg::*;
#(
  parameter hwpe_kind_e KIND = KIND_SUM
) (
  input  logic     clk,
  input  logic     rst_i,
  input  logic     en_i,
  input  cfg_req_t cfg_req_i,
  input  logic     busy_i,
  input  logic     done_i,
  input  data_t    result_i,
  output cfg_rsp_t cfg_rsp_o,
  output logic     start_o,
  output addr_t    base_o,
  output len_t     len_o,
  output addr_t    dest_o
);

  reg_off_t offset;
  logic     wr_en;
  logic     rd_en;
  data_t    rd_data;
  logic     rvalid_q;
  data_t    rdata_q;
  cfg_id_t  rid_q;
  logic     start_q;
  addr_t    base_q;
  len_t     len_q;
  addr_t    dest_q;
  data_t    result_q;

  assign offset = cfg_req_i.add[7:0];
  assign wr_en  = cfg_req_i.req && !cfg_req_i.wen;
  assign rd_en  = cfg_req_i.req && cfg_req_i.wen;

  // Read decode
  always_comb begin
    case (offset)
      REG_STATUS: rd_data = {31'd0, busy_i};
      REG_BASE:   rd_data = base_q;
      REG_LEN:    rd_data = {16'd0, len_q};
      REG_DEST:   rd_data = dest_q;
      REG_RESULT: rd_data = result_q;
      REG_KIND:   rd_data = {31'd0, KIND};
      default:    rd_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
      start_q  <= 1'b0;
      base_q   <= '0;
      len_q    <= '0;
      dest_q   <= '0;
      result_q <= '0;
    end else if (en_i) begin
      rvalid_q <= cfg_req_i.req;
      // Trigger while busy is dropped
      start_q  <= wr_en && (offset == REG_TRIGGER) && !busy_i;
      if (wr_en && offset == REG_BASE) base_q <= cfg_req_i.wdata;
      if (wr_en && offset == REG_LEN)  len_q  <= cfg_req_i.wdata[15:0];
      if (wr_en && offset == REG_DEST) dest_q <= cfg_req_i.wdata;
      if (done_i) result_q <= result_i;
    end
  end

  // Response payload, zero data on writes
  always_ff @(posedge clk) begin
    if (en_i && cfg_req_i.req) begin
      rid_q   <= cfg_req_i.id;
      rdata_q <= rd_en ? rd_data : '0;
    end
  end

  always_comb begin
    cfg_rsp_o.gnt     = cfg_req_i.req;
    cfg_rsp_o.r_valid = rvalid_q;
    cfg_rsp_o.r_data  = rdata_q;
    cfg_rsp_o.r_id    = rid_q;
  end

  assign start_o = start_q;
  assign base_o  = base_q;
  assign len_o   = len_q;
  assign dest_o  = dest_q;

  // Every response answers a request from the last enabled cycle
  assert property (@(posedge clk) disable iff (rst_i)
    $rose(cfg_rsp_o.r_valid) |-> $past(cfg_req_i.req && en_i));

endmodule

`default_nettype wire

//--- logic/hwpe_stream_source.sv
// Stream source
// Issues one memory read per word of a block

`timescale 1ns/100ps
`default_nettype none

module hwpe_stream_source
  import hwpe_pkg::*;
(
  input  logic     clk,
  input  logic     rst_i,
  input  logic     en_i,
  input  logic     start_i,
  input  addr_t    base_i,
  input  len_t     len_i,
  input  logic     mem_gnt_i,
  input  len_t     space_i,
  output mem_req_t mem_req_o,
  output logic     push_o,
  output logic     busy_o
);

  src_state_e state_q;
  addr_t      addr_q;
  len_t       left_q;
  logic       pend_q;
  logic       issue;
  logic       fire;

  // Outstanding read plus buffered words must stay below the depth
  assign issue = en_i && (state_q == SRC_FETCH) && (len_t'(pend_q) < space_i);
  assign fire  = issue && mem_gnt_i;

  always_comb begin
    mem_req_o.req  = issue;
    mem_req_o.add  = addr_q;
    mem_req_o.wen  = 1'b1;
    mem_req_o.data = '0;
  end

  // Read data returns one cycle after the grant
  assign push_o = pend_q;
  assign busy_o = (state_q == SRC_FETCH) || pend_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= SRC_IDLE;
      left_q  <= '0;
      pend_q  <= 1'b0;
    end else if (en_i) begin
      pend_q <= fire;
      case (state_q)
        SRC_IDLE: begin
          if (start_i && len_i != '0) begin
            state_q <= SRC_FETCH;
            left_q  <= len_i;
          end
        end
        SRC_FETCH: begin
          if (fire) begin
            left_q <= left_q - 1'b1;
            if (left_q == len_t'(1)) state_q <= SRC_IDLE;
          end
        end
        default: state_q <= SRC_IDLE;
      endcase
    end
  end

  // Word address, base plus four per issued read
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (start_i && state_q == SRC_IDLE) begin
        addr_q <= base_i;
      end else if (fire) begin
        addr_q <= addr_q + addr_t'(4);
      end
    end
  end

  // A stalled request holds its address
  assert property (@(posedge clk) disable iff (rst_i)
    (mem_req_o.req && !mem_gnt_i) ##1 en_i |-> mem_req_o.req && $stable(mem_req_o.add));

endmodule

`default_nettype wire

//--- logic/hwpe_stream_fifo.sv
// Stream buffer
// Holds read data until the sink takes it

`timescale 1ns/100ps
`default_nettype none

module hwpe_stream_fifo
  import hwpe_pkg::*;
(
  input  logic  clk,
  input  logic  rst_i,
  input  logic  en_i,
  input  logic  push_i,
  input  data_t push_data_i,
  input  logic  pop_i,
  output data_t pop_data_o,
  output logic  empty_o,
  output len_t  free_o
);

  data_t                         mem_q [FIFO_DEPTH];
  logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr_q;
  logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr_q;
  logic [$clog2(FIFO_DEPTH):0]   count_q;
  logic                          do_push;
  logic                          do_pop;

  assign do_push = en_i && push_i;
  assign do_pop  = en_i && pop_i;

  // Pointers wrap naturally at a power of two depth
  always_ff @(posedge clk) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) mem_q[wr_ptr_q] <= push_data_i;
  end

  assign pop_data_o = mem_q[rd_ptr_q];
  assign empty_o    = (count_q == '0);
  assign free_o     = len_t'(FIFO_DEPTH) - len_t'(count_q);

  ////////////////////////////////////////////////////////////////////////////
  // Flow control from source and sink
  ////////////////////////////////////////////////////////////////////////////

  assert property (@(posedge clk) disable iff (rst_i)
    do_push |-> count_q < FIFO_DEPTH);

  assert property (@(posedge clk) disable iff (rst_i)
    do_pop |-> count_q != '0);

endmodule

`default_nettype wire

//--- logic/hwpe_reduce_sink.sv
// Reduction sink
// Sums or takes the maximum, then writes the result back

`timescale 1ns/100ps
`default_nettype none

module hwpe_reduce_sink
  import hwpe_pkg::*;
#(
  parameter hwpe_kind_e KIND = KIND_SUM
) (
  input  logic     clk,
  input  logic     rst_i,
  input  logic     en_i,
  input  logic     start_i,
  input  len_t     len_i,
  input  addr_t    dest_i,
  input  logic     empty_i,
  input  data_t    pop_data_i,
  input  logic     port_free_i,
  input  logic     mem_gnt_i,
  output logic     pop_o,
  output mem_req_t mem_req_o,
  output logic     done_o,
  output data_t    result_o,
  output logic     busy_o
);

  sink_state_e state_q;
  len_t        cnt_q;
  data_t       acc_q;
  data_t       acc_next;
  addr_t       dest_q;
  logic        pop;
  logic        wr_req;

  assign pop    = en_i && (state_q == SINK_REDUCE) && !empty_i;
  assign wr_req = en_i && (state_q == SINK_WRITE) && port_free_i;

  // Modular sum or unsigned max
  always_comb begin
    if (KIND == KIND_SUM) begin
      acc_next = acc_q + pop_data_i;
    end else begin
      acc_next = (pop_data_i > acc_q) ? pop_data_i : acc_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= SINK_IDLE;
      cnt_q   <= '0;
    end else if (en_i) begin
      case (state_q)
        SINK_IDLE: begin
          if (start_i) begin
            cnt_q   <= len_i;
            // Empty job goes straight to the end pulse
            state_q <= (len_i == '0) ? SINK_DONE : SINK_REDUCE;
          end
        end
        SINK_REDUCE: begin
          if (pop) begin
            cnt_q <= cnt_q - 1'b1;
            if (cnt_q == len_t'(1)) state_q <= SINK_WRITE;
          end
        end
        SINK_WRITE: if (wr_req && mem_gnt_i) state_q <= SINK_DONE;
        SINK_DONE:  state_q <= SINK_IDLE;
        default:    state_q <= SINK_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (en_i) begin
      if (start_i && state_q == SINK_IDLE) begin
        acc_q  <= '0;
        dest_q <= dest_i;
      end else if (pop) begin
        acc_q <= acc_next;
      end
    end
  end

  always_comb begin
    mem_req_o.req  = wr_req;
    mem_req_o.add  = dest_q;
    mem_req_o.wen  = 1'b0;
    mem_req_o.data = acc_q;
  end

  assign pop_o    = pop;
  assign done_o   = (state_q == SINK_DONE);
  assign result_o = acc_q;
  assign busy_o   = (state_q == SINK_REDUCE) || (state_q == SINK_WRITE);

endmodule

`default_nettype wire

//--- logic/hwpe_engine.sv
// Reduction engine
// Registers, source, buffer and sink on one memory port

`timescale 1ns/100ps
`default_nettype none

module hwpe_engine
  import hwpe_pkg::*;
#(
  parameter hwpe_kind_e KIND = KIND_SUM
) (
  input  logic     clk,
  input  logic     rst_i,
  input  logic     en_i,
  input  cfg_req_t cfg_req_i,
  input  mem_rsp_t mem_rsp_i,
  output cfg_rsp_t cfg_rsp_o,
  output mem_req_t mem_req_o,
  output logic     busy_o,
  output evt_t     evt_o
);

  logic     start;
  addr_t    base;
  len_t     len;
  addr_t    dest;
  logic     done;
  data_t    result;
  logic     busy;
  logic     src_busy;
  logic     sink_busy;
  logic     src_gnt;
  logic     sink_gnt;
  mem_req_t src_req;
  mem_req_t sink_req;
  logic     src_push;
  logic     fifo_push;
  logic     pop;
  data_t    pop_data;
  logic     empty;
  len_t     free;

  // Pending start covers the gap before source and sink go busy
  assign busy   = start || src_busy || sink_busy;
  assign busy_o = busy;

  hwpe_cfg_regs #(
    .KIND ( KIND )
  ) i_cfg_regs (
    .clk       ( clk       ),
    .rst_i     ( rst_i     ),
    .en_i      ( en_i      ),
    .cfg_req_i ( cfg_req_i ),
    .busy_i    ( busy      ),
    .done_i    ( done      ),
    .result_i  ( result    ),
    .cfg_rsp_o ( cfg_rsp_o ),
    .start_o   ( start     ),
    .base_o    ( base      ),
    .len_o     ( len       ),
    .dest_o    ( dest      )
  );

  hwpe_stream_source i_source (
    .clk       ( clk      ),
    .rst_i     ( rst_i    ),
    .en_i      ( en_i     ),
    .start_i   ( start    ),
    .base_i    ( base     ),
    .len_i     ( len      ),
    .mem_gnt_i ( src_gnt  ),
    .space_i   ( free     ),
    .mem_req_o ( src_req  ),
    .push_o    ( src_push ),
    .busy_o    ( src_busy )
  );

  // Only read returns reach the buffer
  assign fifo_push = src_push && mem_rsp_i.r_valid;

  hwpe_stream_fifo i_fifo (
    .clk         ( clk              ),
    .rst_i       ( rst_i            ),
    .en_i        ( en_i             ),
    .push_i      ( fifo_push        ),
    .push_data_i ( mem_rsp_i.r_data ),
    .pop_i       ( pop              ),
    .pop_data_o  ( pop_data         ),
    .empty_o     ( empty            ),
    .free_o      ( free             )
  );

  hwpe_reduce_sink #(
    .KIND ( KIND )
  ) i_sink (
    .clk         ( clk       ),
    .rst_i       ( rst_i     ),
    .en_i        ( en_i      ),
    .start_i     ( start     ),
    .len_i       ( len       ),
    .dest_i      ( dest      ),
    .empty_i     ( empty     ),
    .pop_data_i  ( pop_data  ),
    .port_free_i ( !src_busy ),
    .mem_gnt_i   ( sink_gnt  ),
    .pop_o       ( pop       ),
    .mem_req_o   ( sink_req  ),
    .done_o      ( done      ),
    .result_o    ( result    ),
    .busy_o      ( sink_busy )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Memory port sharing
  ////////////////////////////////////////////////////////////////////////////

  // Sink only requests once the source has gone idle
  assign mem_req_o = sink_req.req ? sink_req : src_req;
  assign sink_gnt  = mem_rsp_i.gnt && sink_req.req;
  assign src_gnt   = mem_rsp_i.gnt && !sink_req.req;

  // End of job event to every core
  always_comb begin
    evt_o = '0;
    for (int c = 0; c < N_CORES; c++) begin
      evt_o[c][RESET_EVT_BIT] = done;
    end
  end

endmodule

`default_nettype wire

//--- logic/hwpe_subsystem.sv
// Accelerator subsystem top
// Two reduction engines behind one config bus and one memory port

`timescale 1ns/100ps
`default_nettype none

module hwpe_subsystem
  import hwpe_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_i,
  input  logic                     hwpe_en_i,
  input  logic [HWPE_SEL_BITS-1:0] hwpe_sel_i,
  input  cfg_req_t                 cfg_req_i,
  input  mem_rsp_t                 mem_rsp_i,
  output cfg_rsp_t                 cfg_rsp_o,
  output mem_req_t                 mem_req_o,
  output evt_t                     evt_o,
  output logic                     busy_o
);

  logic [N_HWPES-1:0] hwpe_en_int;
  logic [N_HWPES-1:0] busy;
  evt_t               evt         [N_HWPES];
  cfg_req_t           eng_cfg_req [N_HWPES];
  cfg_rsp_t           eng_cfg_rsp [N_HWPES];
  mem_req_t           eng_mem_req [N_HWPES];
  mem_rsp_t           eng_mem_rsp [N_HWPES];

  for (genvar i = 0; i < N_HWPES; i++) begin : gen_hwpe

    // Selected engine advances only while enabled
    assign hwpe_en_int[i] = hwpe_en_i && (hwpe_sel_i == i);

    // Request fields broadcast, req decoded by selection
    assign eng_cfg_req[i] = '{
      req:   cfg_req_i.req && (hwpe_sel_i == i),
      add:   cfg_req_i.add,
      wen:   cfg_req_i.wen,
      wdata: cfg_req_i.wdata,
      id:    cfg_req_i.id
    };

    // Unselected engine sees no grant and no return
    assign eng_mem_rsp[i] = (hwpe_sel_i == i) ? mem_rsp_i : '0;

    hwpe_engine #(
      .KIND ( ENGINE_KINDS[i] )
    ) i_engine (
      .clk       ( clk            ),
      .rst_i     ( rst_i          ),
      .en_i      ( hwpe_en_int[i] ),
      .cfg_req_i ( eng_cfg_req[i] ),
      .mem_rsp_i ( eng_mem_rsp[i] ),
      .cfg_rsp_o ( eng_cfg_rsp[i] ),
      .mem_req_o ( eng_mem_req[i] ),
      .busy_o    ( busy[i]        ),
      .evt_o     ( evt[i]         )
    );

  end

  ////////////////////////////////////////////////////////////////////////////
  // Config response, events and busy
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    cfg_rsp_o = eng_cfg_rsp[0];
    evt_o     = evt[0];
    busy_o    = busy[0];
    for (int i = 1; i < N_HWPES; i++) begin
      if (hwpe_sel_i == i) begin
        cfg_rsp_o = eng_cfg_rsp[i];
        evt_o     = evt[i];
        busy_o    = busy[i];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Memory initiator, static select
  ////////////////////////////////////////////////////////////////////////////

  assign mem_req_o = eng_mem_req[hwpe_sel_i];

  // Selection only moves between jobs
  assert property (@(posedge clk) disable iff (rst_i)
    $changed(hwpe_sel_i) |-> !busy_o && !$past(busy_o));

endmodule

`default_nettype wire

//--- tb/tb_tcdm_mem.sv
// TCDM memory model
// Random grant stalls, read data one cycle after grant

`timescale 1ns/100ps
`default_nettype none

module tb_tcdm_mem
  import hwpe_pkg::*;
(
  input  logic     clk,
  input  logic     rst_i,
  input  mem_req_t mem_req_i,
  output mem_rsp_t mem_rsp_o
);

  localparam int unsigned MEM_WORDS = 256;
  localparam logic [31:0] SEED      = 32'h7f29;

  data_t       mem_q [MEM_WORDS];
  logic [31:0] rng_q    = SEED;
  logic        stall_q  = 1'b0;
  logic        rvalid_q = 1'b0;
  data_t       rdata_q  = '0;
  logic [7:0]  idx;
  logic        gnt;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  assign idx = mem_req_i.add[9:2];
  assign gnt = mem_req_i.req && !stall_q;

  always @(posedge clk) begin
    logic [31:0] fill;
    if (rst_i) begin
      // Preload walks the xorshift sequence over every word
      fill = SEED;
      for (int i = 0; i < MEM_WORDS; i++) begin
        fill = xorshift32(fill);
        mem_q[i] <= fill;
      end
      rng_q    <= SEED;
      stall_q  <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      rng_q    <= xorshift32(rng_q);
      // Roughly one cycle in four refuses the grant
      stall_q  <= (rng_q[1:0] == 2'b00);
      rvalid_q <= gnt && mem_req_i.wen;
      if (gnt && mem_req_i.wen) rdata_q <= mem_q[idx];
      if (gnt && !mem_req_i.wen) mem_q[idx] <= mem_req_i.data;
    end
  end

  always_comb begin
    mem_rsp_o.gnt     = gnt;
    mem_rsp_o.r_valid = rvalid_q;
    mem_rsp_o.r_data  = rdata_q;
  end

endmodule

`default_nettype wire

//--- tb/tb_hwpe_subsystem.sv
// Accelerator subsystem testbench

`timescale 1ns/100ps
`default_nettype none

module tb_hwpe_subsystem
  import hwpe_pkg::*;
();

  localparam int STRESS_JOBS    = 12;
  // Job words times 8 plus slack for configuration traffic
  localparam int JOB_WORDS      = 10 + 12 + 8 + STRESS_JOBS * 20;
  localparam int TIMEOUT_CYCLES = JOB_WORDS * 8 + 2840;
  localparam int JOB_LIMIT      = 20 * 8 + 40;

  logic                     clk;
  logic                     rst;
  logic                     hwpe_en;
  logic [HWPE_SEL_BITS-1:0] hwpe_sel;
  cfg_req_t                 cfg_req;
  cfg_rsp_t                 cfg_rsp;
  mem_req_t                 mem_req;
  mem_rsp_t                 mem_rsp;
  evt_t                     evt;
  logic                     busy;

  logic [31:0] rng_state   = 32'h7f29;
  cfg_id_t     next_id     = '0;
  int          error_count = 0;
  int          pass_tests  = 0;
  int          fail_tests  = 0;
  int          pulse_count = 0;
  int          read_grants = 0;
  int          cycle_count = 0;
  logic        evt_prev    = 1'b0;
  addr_t       exp_addr_q [$];
  data_t       exp_data_q [$];

  hwpe_subsystem DUT (
    .clk        ( clk      ),
    .rst_i      ( rst      ),
    .hwpe_en_i  ( hwpe_en  ),
    .hwpe_sel_i ( hwpe_sel ),
    .cfg_req_i  ( cfg_req  ),
    .mem_rsp_i  ( mem_rsp  ),
    .cfg_rsp_o  ( cfg_rsp  ),
    .mem_req_o  ( mem_req  ),
    .evt_o      ( evt      ),
    .busy_o     ( busy     )
  );

  tb_tcdm_mem i_mem (
    .clk       ( clk     ),
    .rst_i     ( rst     ),
    .mem_req_i ( mem_req ),
    .mem_rsp_o ( mem_rsp )
  );

  always #4 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Modular sum or unsigned max, zero for an empty range
  function automatic data_t reduce_ref(input hwpe_kind_e kind, input addr_t base,
                                       input len_t len);
    data_t      acc;
    data_t      word;
    logic [7:0] idx;
    len_t       i;
    acc = '0;
    idx = base[9:2];
    for (i = '0; i < len; i++) begin
      word = i_mem.mem_q[idx];
      if (kind == KIND_SUM) begin
        acc = acc + word;
      end else if (word > acc) begin
        acc = word;
      end
      idx = idx + 8'd1;
    end
    return acc;
  endfunction

  function automatic evt_t all_core_event();
    evt_t e;
    e = '0;
    for (int c = 0; c < N_CORES; c++) begin
      e[c][RESET_EVT_BIT] = 1'b1;
    end
    return e;
  endfunction

  task automatic check_value(input string what, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (error_count == errors_before) begin
      pass_tests++;
      $display("%0t ns: %s passed", $time, name);
    end else begin
      fail_tests++;
      $display("%0t ns: %s failed with %0d errors", $time, name, error_count - errors_before);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Configuration bus
  ////////////////////////////////////////////////////////////////////////////

  // Called and returning 1 ns after a rising edge
  task automatic cfg_access(input logic is_read, input reg_off_t offset,
                            input data_t wdata, output data_t rdata);
    cfg_id_t id;
    id            = next_id;
    next_id       = next_id + 8'd1;
    rdata         = '0;
    cfg_req.req   = 1'b1;
    cfg_req.add   = {24'd0, offset};
    cfg_req.wen   = is_read;
    cfg_req.wdata = wdata;
    cfg_req.id    = id;
    @(posedge clk);
    #1;
    cfg_req.req = 1'b0;
    // Response is due exactly one cycle after the grant
    if (!cfg_rsp.r_valid) begin
      $display("ERROR: no configuration response one cycle after request id %0d", id);
      error_count++;
    end else begin
      check_value("response id", data_t'(cfg_rsp.r_id), data_t'(id));
      rdata = cfg_rsp.r_data;
      if (!is_read) check_value("write response data", rdata, '0);
    end
  endtask

  task automatic cfg_write(input reg_off_t offset, input data_t wdata);
    data_t unused;
    cfg_access(1'b0, offset, wdata, unused);
  endtask

  task automatic cfg_read(input reg_off_t offset, output data_t rdata);
    cfg_access(1'b1, offset, '0, rdata);
  endtask

  task automatic select_engine(input logic [HWPE_SEL_BITS-1:0] eng);
    hwpe_sel = eng;
    @(posedge clk);
    #1;
  endtask

  // Program, trigger and wait for the end pulse
  task automatic run_job(input logic [HWPE_SEL_BITS-1:0] eng, input addr_t base,
                         input len_t len, input addr_t dest, input logic retrigger,
                         input logic drop_en);
    hwpe_kind_e kind;
    data_t      expected;
    data_t      rd;
    int         pulses_before;
    int         grants_before;
    int         cycles;
    logic       done;
    logic       retrig_pending;
    kind = ENGINE_KINDS[eng];
    select_engine(eng);
    cfg_write(REG_BASE, base);
    cfg_write(REG_LEN, data_t'(len));
    cfg_write(REG_DEST, dest);
    expected = reduce_ref(kind, base, len);
    if (len != '0) begin
      exp_addr_q.push_back(dest);
      exp_data_q.push_back(expected);
    end
    pulses_before  = pulse_count;
    grants_before  = read_grants;
    retrig_pending = retrigger;
    cfg_write(REG_TRIGGER, '0);
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < JOB_LIMIT) begin
      if (evt[0][RESET_EVT_BIT]) begin
        done = 1'b1;
        check_value("busy in end pulse cycle", data_t'(busy), '0);
      end else begin
        check_value("busy during job", data_t'(busy), 32'd1);
        if (retrig_pending && read_grants - grants_before == int'(len)) begin
          // Second trigger lands as the source goes idle with the sink still busy
          retrig_pending = 1'b0;
          cfg_write(REG_TRIGGER, '0);
        end else begin
          rng_state = xorshift32(rng_state);
          // Pause only with no read data in flight
          hwpe_en = !(drop_en && !mem_rsp.r_valid && rng_state[2:0] == 3'd0);
          @(posedge clk);
          #1;
        end
        cycles++;
      end
    end
    hwpe_en = 1'b1;
    if (!done) begin
      $display("ERROR: job on engine %0d did not end within %0d cycles", eng, JOB_LIMIT);
      error_count++;
    end
    if (retrig_pending) begin
      $display("ERROR: second trigger on engine %0d was never issued", eng);
      error_count++;
    end
    repeat (3) @(posedge clk);
    #1;
    check_value("end pulses per job", data_t'(pulse_count - pulses_before), 32'd1);
    if (exp_addr_q.size() != 0) begin
      $display("ERROR: result of engine %0d never reached address %h", eng, dest);
      error_count++;
      exp_addr_q.delete();
      exp_data_q.delete();
    end
    cfg_read(REG_RESULT, rd);
    check_value("result register", rd, expected);
    cfg_read(REG_STATUS, rd);
    check_value("status after job", rd, '0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus monitor and result compare
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (!rst) begin
      check_value("config grant", data_t'(cfg_rsp.gnt), data_t'(cfg_req.req));
      if (!hwpe_en && mem_req.req) begin
        $display("ERROR: memory request at %0t ns while the engines are disabled", $time);
        error_count++;
      end
      if (mem_req.req && mem_rsp.gnt && mem_req.wen) read_grants++;
      if (mem_req.req && mem_rsp.gnt && !mem_req.wen) begin
        if (exp_addr_q.size() == 0) begin
          $display("ERROR: unexpected memory write to %h at %0t ns", mem_req.add, $time);
          error_count++;
        end else begin
          check_value("written address", mem_req.add, exp_addr_q.pop_front());
          check_value("written result", mem_req.data, exp_data_q.pop_front());
        end
      end
      if (evt !== '0) check_value("event vector", data_t'(evt), data_t'(all_core_event()));
      if (evt[0][RESET_EVT_BIT] && !evt_prev) pulse_count++;
      evt_prev = evt[0][RESET_EVT_BIT];
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("ERROR: run hung, still going after %0d cycles", cycle_count);
      $display("Test FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int                       errs;
    int                       job;
    logic [HWPE_SEL_BITS-1:0] eng;
    len_t                     len;
    addr_t                    base;
    data_t                    rd;
    clk      = 1'b0;
    rst      = 1'b1;
    hwpe_en  = 1'b1;
    hwpe_sel = '0;
    cfg_req  = '0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    @(posedge clk);
    #1;

    errs = error_count;
    run_job(1'b0, 32'h040, 16'd10, 32'h300, 1'b0, 1'b0);
    report_test("sum job on engine 0", errs);

    errs = error_count;
    run_job(1'b1, 32'h100, 16'd12, 32'h304, 1'b0, 1'b0);
    cfg_read(REG_KIND, rd);
    check_value("kind of engine 1", rd, 32'd1);
    select_engine(1'b0);
    cfg_read(REG_KIND, rd);
    check_value("kind of engine 0", rd, 32'd0);
    report_test("max job on engine 1", errs);

    errs = error_count;
    select_engine(1'b1);
    cfg_write(REG_BASE, 32'h0000_0abc);
    select_engine(1'b0);
    cfg_read(REG_BASE, rd);
    check_value("engine 0 base", rd, 32'h040);
    select_engine(1'b1);
    cfg_read(REG_BASE, rd);
    check_value("engine 1 base", rd, 32'h0000_0abc);
    report_test("selection isolation", errs);

    errs = error_count;
    run_job(1'b0, 32'h200, 16'd8, 32'h308, 1'b1, 1'b0);
    run_job(1'b1, 32'h280, 16'd0, 32'h30c, 1'b0, 1'b0);
    report_test("status, events and empty job", errs);

    // Random lengths and engines with enable pauses
    errs = error_count;
    for (job = 0; job < STRESS_JOBS; job++) begin
      rng_state = xorshift32(rng_state);
      eng       = rng_state[4 +: HWPE_SEL_BITS];
      len       = len_t'(rng_state % 32'd20) + 16'd1;
      rng_state = xorshift32(rng_state);
      base      = (rng_state % 32'd160) * 32'd4;
      run_job(eng, base, len, 32'h300 + addr_t'(job * 4), 1'b0, 1'b1);
    end
    report_test("random stress", errs);

    $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
             pass_tests, fail_tests, error_count);
    if (fail_tests == 0 && error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
logic/hwpe_pkg.sv
logic/hwpe_cfg_regs.sv
logic/hwpe_stream_source.sv
logic/hwpe_stream_fifo.sv
logic/hwpe_reduce_sink.sv
logic/hwpe_engine.sv
logic/hwpe_subsystem.sv
tb/tb_tcdm_mem.sv
tb/tb_hwpe_subsystem.sv

//--- Makefile
# Verilator build and run for the accelerator subsystem

VERILATOR ?= verilator
TOP       ?= tb_hwpe_subsystem
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0 --timescale 1ns/100ps

SRCS := $(shell grep -E '\.(sv|v)$$' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q '^Test OK$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
